// ==== compile.f ====
+incdir+rtl
rtl/i2c_pkg.sv
rtl/i2c_input_filter.sv
rtl/i2c_bit_ctl.sv
rtl/i2c_byte_ctl.sv
rtl/i2c_master_top.sv
verif/i2c_slave_model.sv
verif/tb_i2c_master.sv

// ==== Makefile ====
TOP = tb_i2c_master

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o sim

run: build
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only -Wall +incdir+rtl rtl/i2c_pkg.sv rtl/i2c_input_filter.sv \
		rtl/i2c_bit_ctl.sv rtl/i2c_byte_ctl.sv rtl/i2c_master_top.sv \
		--top-module i2c_master_top

clean:
	rm -rf obj_dir

// ==== verif/i2c_stim.txt ====
// columns packed in one hex word: c dd ee a f
// c command, dd data, ee expected byte, a expected ack (F none), f flags
10000F0
2A000F0
4000000
23C00F0
4003C08
25A00F0
4005A08
800FFF4
10000F0
2B000F0
4000010
800FFF4
70000F0
2A100F0
4000000
3003CF4
50000F0
3005AF4
60000F0
800FFF4
10000F1
2A000F1
4000001
23C00F1
4003C09
25A00F1
4005A09
800FFF5
10000F0
2A000F0
4000000
2FF00F2

// ==== verif/tb_i2c_master.sv ====
`timescale 1ns/1ps
`include "i2c_defines.svh"

module tb_i2c_master;

    localparam int    STIM_MAX = 64;
    localparam int    PRESCALE = 4;
    localparam longint BIT_NS  = 4 * (PRESCALE + 1) * 100;

    logic                   i_sysclk = 1'b0;
    logic                   i_rst_n;
    logic                   i_enable;
    logic                   i_cmd_trig;
    i2c_pkg::i2c_cmd_e      i_cmd;
    logic [`I2C_DATA_W-1:0] i_data;
    i2c_pkg::i2c_status_t   o_status;
    logic [`I2C_DATA_W-1:0] o_data;
    logic                   scl_line;
    logic                   sda_line;
    logic                   o_scl;
    logic                   o_scl_oen;
    logic                   o_sda;
    logic                   o_sda_oen;
    logic [7:0]             slv_stretch;
    logic                   slv_arb;
    logic                   slv_scl_pull;
    logic                   slv_sda_pull;
    logic [`I2C_DATA_W-1:0] slv_last_wr;
    logic [27:0]            stim [0:STIM_MAX-1];
    logic                   exp_busy = 1'b0;
    int                     err_cnt = 0;
    int                     n_pass = 0;
    int                     n_fail = 0;
    longint                 limit_ns = 0;
    logic                   limit_ready = 1'b0;

    always #50 i_sysclk = ~i_sysclk;

    // pull-ups with wired-and of master and slave
    assign scl_line = (o_scl_oen ? 1'b1 : o_scl) & ~slv_scl_pull;
    assign sda_line = (o_sda_oen ? 1'b1 : o_sda) & ~slv_sda_pull;

    i2c_master_top uut (
        .i_sysclk   (i_sysclk),
        .i_rst_n    (i_rst_n),
        .i_enable   (i_enable),
        .i_prescale (16'(PRESCALE)),
        .i_dfsr     (6'd1),
        .i_cmd_trig (i_cmd_trig),
        .i_cmd      (i_cmd),
        .i_data     (i_data),
        .o_status   (o_status),
        .o_data     (o_data),
        .i_scl      (scl_line),
        .o_scl      (o_scl),
        .o_scl_oen  (o_scl_oen),
        .i_sda      (sda_line),
        .o_sda      (o_sda),
        .o_sda_oen  (o_sda_oen)
    );

    i2c_slave_model #(.ADDR(7'h50)) slave (
        .i_scl       (scl_line),
        .i_sda       (sda_line),
        .i_stretch   (slv_stretch),
        .i_arb_force (slv_arb),
        .o_scl_pull  (slv_scl_pull),
        .o_sda_pull  (slv_sda_pull),
        .o_last_wr   (slv_last_wr)
    );

    task automatic check_byte(input string what, input logic [`I2C_DATA_W-1:0] got,
                              input logic [`I2C_DATA_W-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input string what, input i2c_pkg::i2c_status_t got,
                                input i2c_pkg::i2c_status_t exp,
                                input i2c_pkg::i2c_status_t care);
        if (((got ^ exp) & care) !== '0) begin
            err_cnt++;
            $display("[FAIL] %0d ns: %s status %04b, expected %04b under mask %04b",
                     $time, what, got, exp, care);
        end
    endtask

    task automatic check_pad(input string what, input i2c_pkg::i2c_pad_t got,
                             input i2c_pkg::i2c_pad_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0d ns: %s pads %04b, expected %04b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic next_cycle();
        @(posedge i_sysclk);
        #10;
    endtask

    task automatic run_line(input int num, input logic [27:0] word);
        logic [3:0]           cmd;
        logic [7:0]           exp_data;
        logic [3:0]           exp_ack;
        logic [3:0]           flags;
        logic                 al_seen;
        int                   errs_before;
        i2c_pkg::i2c_status_t got;
        i2c_pkg::i2c_status_t exp;
        i2c_pkg::i2c_status_t care;
        cmd         = word[27:24];
        exp_data    = word[15:8];
        exp_ack     = word[7:4];
        flags       = word[3:0];
        errs_before = err_cnt;
        al_seen     = 1'b0;
        slv_stretch = flags[0] ? 8'(5 + ($urandom % 36)) : 8'd0;
        slv_arb     = flags[1];
        if (cmd == i2c_pkg::CMD_START || cmd == i2c_pkg::CMD_RESTART) begin
            exp_busy = 1'b1;
        end else if (cmd == i2c_pkg::CMD_STOP) begin
            exp_busy = 1'b0;
        end
        i_cmd      = i2c_pkg::i2c_cmd_e'(cmd);
        i_data     = word[23:16];
        i_cmd_trig = 1'b1;
        next_cycle();
        i_cmd_trig = 1'b0;
        while (o_status.cmd_ack !== 1'b1) begin
            al_seen = al_seen | o_status.al;   // al comes one cycle ahead of cmd_ack
            next_cycle();
        end
        got    = o_status;
        got.al = al_seen;
        next_cycle();
        got.cmd_ack = o_status.cmd_ack;   // cmd_ack lasts one cycle
        exp    = '{cmd_ack: 1'b0, ack: exp_ack[0], al: flags[1], busy: exp_busy};
        care   = '{cmd_ack: 1'b1, ack: (exp_ack != 4'hF), al: 1'b1, busy: 1'b1};
        check_status($sformatf("line %0d", num), got, exp, care);
        if (flags[2]) begin
            check_byte("o_data", o_data, exp_data);
        end
        if (flags[3]) begin
            check_byte("slave memory", slv_last_wr, exp_data);
        end
        report_test($sformatf("%0d %s", num, i_cmd.name()), errs_before);
    endtask

    task automatic disable_check();
        int errs_before;
        errs_before = err_cnt;
        // read with sda still forced low so scl stays driven and o_data is zero
        i_cmd      = i2c_pkg::CMD_READ;
        i_data     = '0;
        i_cmd_trig = 1'b1;
        next_cycle();
        i_cmd_trig = 1'b0;
        while (o_status.cmd_ack !== 1'b1) begin
            next_cycle();
        end
        check_byte("o_data forced low", o_data, 8'h00);
        check_pad("before disable", '{scl_o: o_scl, scl_oen: o_scl_oen, sda_o: o_sda,
                                      sda_oen: o_sda_oen},
                  '{scl_o: 1'b0, scl_oen: 1'b0, sda_o: 1'b0, sda_oen: 1'b1});
        i_enable    = 1'b0;
        repeat (3) next_cycle();
        check_pad("disabled", '{scl_o: o_scl, scl_oen: o_scl_oen, sda_o: o_sda,
                                sda_oen: o_sda_oen},
                  '{scl_o: 1'b0, scl_oen: 1'b1, sda_o: 1'b0, sda_oen: 1'b1});
        check_byte("o_data disabled", o_data, 8'hFF);
        check_status("busy held", o_status, '{cmd_ack: 1'b0, ack: 1'b0, al: 1'b0, busy: 1'b1},
                     '{cmd_ack: 1'b1, ack: 1'b0, al: 1'b1, busy: 1'b1});
        slv_arb = 1'b0;   // sda rises with scl high for a stop
        repeat (20) next_cycle();
        check_status("after stop", o_status, '0,
                     '{cmd_ack: 1'b1, ack: 1'b0, al: 1'b1, busy: 1'b1});
        report_test("disable", errs_before);
    endtask

    initial begin
        wait (limit_ready);
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int     n_stim;
        int     errs_before;
        longint bits;
        longint stretch_bits;
        void'($urandom(32'h4ce8_f600));
        i_rst_n      = 1'b0;
        i_enable     = 1'b1;
        i_cmd_trig   = 1'b0;
        i_cmd        = i2c_pkg::CMD_IDLE;
        i_data       = '0;
        slv_stretch  = 8'd0;
        slv_arb      = 1'b0;
        n_stim       = 0;
        bits         = 0;
        stretch_bits = 0;
        for (int i = 0; i < STIM_MAX; i++) begin
            stim[i] = '1;   // cmd F marks the end
        end
        $readmemh("verif/i2c_stim.txt", stim);
        while (n_stim < STIM_MAX && stim[n_stim][27:24] != 4'hF) begin
            if (stim[n_stim][27:24] == i2c_pkg::CMD_WRITE ||
                stim[n_stim][27:24] == i2c_pkg::CMD_READ) begin
                bits += 8;
                stretch_bits += stim[n_stim][0] ? 8 : 0;
            end else begin
                bits += 1;
                stretch_bits += stim[n_stim][0] ? 1 : 0;
            end
            if (stim[n_stim][1]) begin
                bits += 8;   // read ahead of the disable check
            end
            n_stim++;
        end
        limit_ns    = 2 * bits * BIT_NS + stretch_bits * 40 * 100 + 10000;
        limit_ready = 1'b1;

        repeat (3) @(posedge i_sysclk);
        #10;
        i_rst_n = 1'b1;
        repeat (2) next_cycle();
        errs_before = err_cnt;
        check_status("reset", o_status, '0, '{cmd_ack: 1'b1, ack: 1'b0, al: 1'b1, busy: 1'b1});
        check_byte("o_data reset", o_data, 8'hFF);
        report_test("reset", errs_before);

        for (int i = 0; i < n_stim; i++) begin
            run_line(i, stim[i]);
            if (stim[i][1]) begin
                disable_check();
            end
        end

        $display("tests passed %0d, tests failed %0d, check errors %0d", n_pass, n_fail, err_cnt);
        if (err_cnt == 0 && n_fail == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verif/i2c_slave_model.sv ====
`timescale 1ns/1ps
`include "i2c_defines.svh"

module i2c_slave_model #(
    parameter logic [6:0] ADDR = 7'h50
) (
    input  logic                   i_scl,
    input  logic                   i_sda,
    input  logic [7:0]             i_stretch,     // scl hold in 100 ns steps, 0 is off
    input  logic                   i_arb_force,   // hold sda low against the master
    output logic                   o_scl_pull,
    output logic                   o_sda_pull,
    output logic [`I2C_DATA_W-1:0] o_last_wr
);

    typedef enum logic [2:0] {
        S_IDLE, S_ADDR, S_ADDR_ACK, S_WDATA, S_WACK, S_RDATA, S_RACK
    } slv_state_e;

    slv_state_e             state    = S_IDLE;
    logic [`I2C_DATA_W-1:0] mem [0:15];
    logic [3:0]             idx      = 4'd0;
    logic [`I2C_DATA_W-1:0] sr       = '0;
    logic [`I2C_DATA_W-1:0] rd_byte  = '1;
    logic [3:0]             cnt      = 4'd0;
    logic                   rw       = 1'b0;
    logic                   m_ack    = 1'b1;
    logic                   drv_low  = 1'b0;
    logic                   scl_q    = 1'b1;
    logic                   sda_q    = 1'b1;
    logic                   scl_hold = 1'b0;

    assign o_sda_pull = drv_low | i_arb_force;
    assign o_scl_pull = scl_hold;

    initial begin
        o_last_wr = '0;
    end

    always @(posedge i_scl or negedge i_scl or posedge i_sda or negedge i_sda) begin
        scl_q <= i_scl;
        sda_q <= i_sda;
        if (scl_q && i_scl && sda_q && !i_sda) begin   // start
            state   <= S_ADDR;
            cnt     <= 4'd0;
            drv_low <= 1'b0;
        end else if (scl_q && i_scl && !sda_q && i_sda) begin   // stop
            state   <= S_IDLE;
            drv_low <= 1'b0;
        end else if (!scl_q && i_scl) begin
            if (state == S_ADDR || state == S_WDATA) begin
                sr  <= {sr[6:0], i_sda};
                cnt <= cnt + 4'd1;
            end
            if (state == S_RACK) begin
                m_ack <= i_sda;
            end
        end else if (scl_q && !i_scl) begin
            case (state)
                S_ADDR: begin
                    if (cnt == 4'd8) begin
                        if (sr[7:1] == ADDR) begin
                            drv_low <= 1'b1;
                            rw      <= sr[0];
                            idx     <= 4'd0;
                            state   <= S_ADDR_ACK;
                        end else begin
                            state <= S_IDLE;   // not ours, line stays released
                        end
                    end
                end
                S_ADDR_ACK: begin
                    if (rw) begin
                        drv_low <= ~mem[idx][7];
                        rd_byte <= {mem[idx][6:0], 1'b1};
                        idx     <= idx + 4'd1;
                        cnt     <= 4'd1;
                        state   <= S_RDATA;
                    end else begin
                        drv_low <= 1'b0;
                        cnt     <= 4'd0;
                        state   <= S_WDATA;
                    end
                end
                S_WDATA: begin
                    if (cnt == 4'd8) begin
                        mem[idx]  <= sr;
                        o_last_wr <= sr;
                        idx       <= idx + 4'd1;
                        drv_low   <= 1'b1;
                        state     <= S_WACK;
                    end
                end
                S_WACK: begin
                    drv_low <= 1'b0;
                    cnt     <= 4'd0;
                    state   <= S_WDATA;
                end
                S_RDATA: begin
                    if (cnt == 4'd8) begin
                        drv_low <= 1'b0;
                        state   <= S_RACK;
                    end else begin
                        drv_low <= ~rd_byte[7];
                        rd_byte <= {rd_byte[6:0], 1'b1};
                        cnt     <= cnt + 4'd1;
                    end
                end
                S_RACK: begin
                    if (!m_ack) begin
                        drv_low <= ~mem[idx][7];
                        rd_byte <= {mem[idx][6:0], 1'b1};
                        idx     <= idx + 4'd1;
                        cnt     <= 4'd1;
                        state   <= S_RDATA;
                    end else begin
                        state <= S_IDLE;   // master nak ends the read
                    end
                end
                default: begin
                    drv_low <= 1'b0;
                end
            endcase
        end
    end

    // hold scl low after each falling edge
    always @(negedge i_scl) begin
        if (i_stretch != 8'd0) begin
            scl_hold <= 1'b1;
            #(int'(i_stretch) * 100);
            scl_hold <= 1'b0;
        end
    end

endmodule

// ==== rtl/i2c_master_top.sv ====
`timescale 1ns/1ps
`include "i2c_defines.svh"

module i2c_master_top (
    input  logic                       i_sysclk,
    input  logic                       i_rst_n,
    input  logic                       i_enable,
    input  logic [`I2C_PRESCALE_W-1:0] i_prescale,
    input  logic [`I2C_DFSR_W-1:0]     i_dfsr,
    input  logic                       i_cmd_trig,
    input  i2c_pkg::i2c_cmd_e          i_cmd,
    input  logic [`I2C_DATA_W-1:0]     i_data,
    output i2c_pkg::i2c_status_t       o_status,
    output logic [`I2C_DATA_W-1:0]     o_data,
    input  logic                       i_scl,
    output logic                       o_scl,
    output logic                       o_scl_oen,
    input  logic                       i_sda,
    output logic                       o_sda,
    output logic                       o_sda_oen
);

    i2c_pkg::i2c_cfg_t  cfg;
    i2c_pkg::i2c_line_t pad_line;   // raw pad inputs
    i2c_pkg::i2c_pad_t  pad;

    assign cfg.enable   = i_enable;
    assign cfg.prescale = i_prescale;
    assign cfg.dfsr     = i_dfsr;

    assign pad_line.scl = i_scl;
    assign pad_line.sda = i_sda;

    assign o_scl     = pad.scl_o;
    assign o_scl_oen = pad.scl_oen;
    assign o_sda     = pad.sda_o;
    assign o_sda_oen = pad.sda_oen;

    i2c_byte_ctl u_byte_ctl (
        .i_sysclk   (i_sysclk),
        .i_rst_n    (i_rst_n),
        .i_cfg      (cfg),
        .i_cmd_trig (i_cmd_trig),
        .i_cmd      (i_cmd),
        .i_data     (i_data),
        .o_status   (o_status),
        .o_data     (o_data),
        .i_line     (pad_line),
        .o_pad      (pad)
    );

endmodule

// ==== rtl/i2c_byte_ctl.sv ====
`timescale 1ns/1ps
`include "i2c_defines.svh"

module i2c_byte_ctl (
    input  logic                   i_sysclk,
    input  logic                   i_rst_n,
    input  i2c_pkg::i2c_cfg_t      i_cfg,
    input  logic                   i_cmd_trig,
    input  i2c_pkg::i2c_cmd_e      i_cmd,
    input  logic [`I2C_DATA_W-1:0] i_data,
    output i2c_pkg::i2c_status_t   o_status,
    output logic [`I2C_DATA_W-1:0] o_data,
    input  i2c_pkg::i2c_line_t     i_line,
    output i2c_pkg::i2c_pad_t      o_pad
);

    localparam int               CNT_W   = $clog2(`I2C_DATA_W);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`I2C_DATA_W - 1);
    localparam int               MSB     = `I2C_DATA_W - 1;

    i2c_pkg::i2c_cmd_e      cur_cmd;
    i2c_pkg::i2c_bit_cmd_e  bit_cmd;
    logic                   bit_din;
    logic                   bit_done;
    logic                   bit_dout;
    logic                   bit_al;
    logic [`I2C_DATA_W-1:0] shift_r;
    logic [CNT_W-1:0]       bit_cnt;
    logic                   cmd_ack;
    logic                   ack_r;
    logic                   bus_busy;
    i2c_pkg::i2c_line_t     filt_line;

    assign o_status.cmd_ack = cmd_ack;
    assign o_status.ack     = ack_r;
    assign o_status.al      = bit_al;     // seen one clock ahead of cmd_ack
    assign o_status.busy    = bus_busy;

    always_ff @(posedge i_sysclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cur_cmd <= i2c_pkg::CMD_IDLE;
            bit_cmd <= i2c_pkg::BIT_IDLE;
            bit_din <= 1'b1;
            shift_r <= '1;
            bit_cnt <= CNT_MAX;
            cmd_ack <= 1'b0;
            ack_r   <= 1'b0;
            o_data  <= '1;
        end else if (!i_cfg.enable) begin
            cur_cmd <= i2c_pkg::CMD_IDLE;
            bit_cmd <= i2c_pkg::BIT_IDLE;
            bit_din <= 1'b1;
            bit_cnt <= CNT_MAX;
            cmd_ack <= 1'b0;
            ack_r   <= 1'b0;
            o_data  <= '1;
        end else begin
            bit_cmd <= i2c_pkg::BIT_IDLE;   // bit commands are single pulses
            cmd_ack <= 1'b0;
            if (i_cmd_trig) begin
                cur_cmd <= i_cmd;
                bit_cnt <= CNT_MAX;
                case (i_cmd)
                    i2c_pkg::CMD_START: begin
                        bit_cmd <= i2c_pkg::BIT_START;
                    end
                    i2c_pkg::CMD_WRITE: begin
                        shift_r <= i_data;
                        bit_din <= i_data[MSB];   // msb first
                        bit_cmd <= i2c_pkg::BIT_WRITE;
                    end
                    i2c_pkg::CMD_READ, i2c_pkg::CMD_RD_ACK: begin
                        bit_din <= 1'b1;
                        bit_cmd <= i2c_pkg::BIT_READ;
                    end
                    i2c_pkg::CMD_WR_ACK: begin
                        bit_din <= 1'b0;
                        bit_cmd <= i2c_pkg::BIT_WRITE;
                    end
                    i2c_pkg::CMD_WR_NAK: begin
                        bit_din <= 1'b1;
                        bit_cmd <= i2c_pkg::BIT_WRITE;
                    end
                    i2c_pkg::CMD_RESTART: begin
                        bit_cmd <= i2c_pkg::BIT_RESTART;
                    end
                    i2c_pkg::CMD_STOP: begin
                        bit_cmd <= i2c_pkg::BIT_STOP;
                    end
                    default: begin
                        cmd_ack <= 1'b1;   // nothing to put on the bus
                    end
                endcase
            end
            if (bit_done) begin
                if (bit_al) begin
                    cmd_ack <= 1'b1;
                    cur_cmd <= i2c_pkg::CMD_IDLE;
                end else begin
                    case (cur_cmd)
                        i2c_pkg::CMD_WRITE: begin
                            if (bit_cnt == '0) begin
                                cmd_ack <= 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt - 1'b1;
                                shift_r <= {shift_r[MSB-1:0], 1'b1};
                                bit_din <= shift_r[MSB-1];
                                bit_cmd <= i2c_pkg::BIT_WRITE;
                            end
                        end
                        i2c_pkg::CMD_READ: begin
                            shift_r <= {shift_r[MSB-1:0], bit_dout};
                            if (bit_cnt == '0) begin
                                o_data  <= {shift_r[MSB-1:0], bit_dout};
                                cmd_ack <= 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt - 1'b1;
                                bit_cmd <= i2c_pkg::BIT_READ;
                            end
                        end
                        i2c_pkg::CMD_RD_ACK: begin
                            ack_r   <= bit_dout;   // 0 means slave acked
                            cmd_ack <= 1'b1;
                        end
                        i2c_pkg::CMD_STOP: begin
                            o_data  <= '1;
                            cmd_ack <= 1'b1;
                        end
                        default: begin
                            cmd_ack <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

    i2c_input_filter u_filter (
        .i_sysclk (i_sysclk),
        .i_rst_n  (i_rst_n),
        .i_cfg    (i_cfg),
        .i_line   (i_line),
        .o_line   (filt_line),
        .o_busy   (bus_busy)
    );

    i2c_bit_ctl u_bit_ctl (
        .i_sysclk  (i_sysclk),
        .i_rst_n   (i_rst_n),
        .i_cfg     (i_cfg),
        .i_bit_cmd (bit_cmd),
        .i_din     (bit_din),
        .o_done    (bit_done),
        .o_dout    (bit_dout),
        .o_al      (bit_al),
        .i_line    (filt_line),
        .o_pad     (o_pad)
    );

endmodule

// ==== rtl/i2c_bit_ctl.sv ====
`timescale 1ns/1ps
`include "i2c_defines.svh"

module i2c_bit_ctl (
    input  logic                  i_sysclk,
    input  logic                  i_rst_n,
    input  i2c_pkg::i2c_cfg_t     i_cfg,
    input  i2c_pkg::i2c_bit_cmd_e i_bit_cmd,
    input  logic                  i_din,
    output logic                  o_done,
    output logic                  o_dout,
    output logic                  o_al,
    input  i2c_pkg::i2c_line_t    i_line,
    output i2c_pkg::i2c_pad_t     o_pad
);

    localparam i2c_pkg::i2c_pad_t PAD_REL = '{
        scl_o:   1'b0,
        scl_oen: 1'b1,
        sda_o:   1'b0,
        sda_oen: 1'b1
    };

    logic [`I2C_PRESCALE_W-1:0] clk_cnt;
    logic                       active;
    logic [1:0]                 phase;     // A=0 .. D=3
    i2c_pkg::i2c_bit_cmd_e      kind;
    logic                       din_q;
    logic                       stall;
    logic                       smp_pt;
    logic                       lost;

    // pad levels for one phase of one command
    function automatic i2c_pkg::i2c_pad_t phase_pad(
        input i2c_pkg::i2c_bit_cmd_e cmd,
        input logic [1:0]            ph,
        input logic                  din,
        input logic                  scl_now
    );
        logic scl_rel;
        logic sda_rel;
        scl_rel = 1'b1;
        sda_rel = 1'b1;
        case (cmd)
            i2c_pkg::BIT_START: begin
                scl_rel = (ph != 2'd3);
                sda_rel = (ph <= 2'd1);   // sda falls in C with scl high
            end
            i2c_pkg::BIT_RESTART: begin
                scl_rel = (ph == 2'd0) ? scl_now : (ph != 2'd3);
                sda_rel = (ph <= 2'd1);
            end
            i2c_pkg::BIT_STOP: begin
                scl_rel = (ph != 2'd0);
                sda_rel = (ph >= 2'd2);   // sda rises in C with scl high
            end
            i2c_pkg::BIT_WRITE: begin
                scl_rel = (ph == 2'd1) || (ph == 2'd2);
                sda_rel = din;
            end
            i2c_pkg::BIT_READ: begin
                scl_rel = (ph == 2'd1) || (ph == 2'd2);
                sda_rel = 1'b1;
            end
            default: begin
                scl_rel = 1'b1;
                sda_rel = 1'b1;
            end
        endcase
        return '{scl_o: 1'b0, scl_oen: scl_rel, sda_o: 1'b0, sda_oen: sda_rel};
    endfunction

    // slave holding scl low after release
    assign stall = o_pad.scl_oen & ~i_line.scl;

    // end of phase B is the middle of scl high
    assign smp_pt = (phase == 2'd1) &&
                    ((kind == i2c_pkg::BIT_WRITE) || (kind == i2c_pkg::BIT_READ));
    assign lost   = smp_pt && (kind == i2c_pkg::BIT_WRITE) && o_pad.sda_oen && !i_line.sda;

    always_ff @(posedge i_sysclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            clk_cnt <= '0;
            active  <= 1'b0;
            phase   <= 2'd0;
            kind    <= i2c_pkg::BIT_IDLE;
            din_q   <= 1'b1;
            o_done  <= 1'b0;
            o_dout  <= 1'b1;
            o_al    <= 1'b0;
            o_pad   <= PAD_REL;
        end else if (!i_cfg.enable) begin
            clk_cnt <= '0;
            active  <= 1'b0;
            phase   <= 2'd0;
            kind    <= i2c_pkg::BIT_IDLE;
            o_done  <= 1'b0;
            o_al    <= 1'b0;
            o_pad   <= PAD_REL;
        end else begin
            o_done <= 1'b0;
            o_al   <= 1'b0;
            if (!active) begin
                if (i_bit_cmd != i2c_pkg::BIT_IDLE) begin
                    active  <= 1'b1;
                    kind    <= i_bit_cmd;
                    din_q   <= i_din;
                    phase   <= 2'd0;
                    clk_cnt <= i_cfg.prescale;
                    o_pad   <= phase_pad(i_bit_cmd, 2'd0, i_din, o_pad.scl_oen);
                end
            end else if (stall) begin
                clk_cnt <= i_cfg.prescale;   // count only once scl is seen high
            end else if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= i_cfg.prescale;
                if (smp_pt) begin
                    o_dout <= i_line.sda;
                end
                if (lost) begin
                    o_al   <= 1'b1;
                    o_done <= 1'b1;
                    active <= 1'b0;
                    o_pad  <= PAD_REL;   // back off the bus
                end else if (phase == 2'd3) begin
                    o_done <= 1'b1;
                    active <= 1'b0;
                end else begin
                    phase <= phase + 2'd1;
                    o_pad <= phase_pad(kind, phase + 2'd1, din_q, o_pad.scl_oen);
                end
            end
        end
    end

endmodule

// ==== rtl/i2c_input_filter.sv ====
`timescale 1ns/1ps
`include "i2c_defines.svh"

module i2c_input_filter (
    input  logic               i_sysclk,
    input  logic               i_rst_n,
    input  i2c_pkg::i2c_cfg_t  i_cfg,
    input  i2c_pkg::i2c_line_t i_line,
    output i2c_pkg::i2c_line_t o_line,
    output logic               o_busy
);

    logic [`I2C_DFSR_W-1:0] smp_cnt;
    logic                   smp_stb;
    logic [2:0]             scl_sr;
    logic [2:0]             sda_sr;
    i2c_pkg::i2c_line_t     line_q;    // filtered value one clock back
    logic                   sta_det;
    logic                   sto_det;

    function automatic logic maj3(input logic [2:0] v);
        return (v[0] & v[1]) | (v[0] & v[2]) | (v[1] & v[2]);
    endfunction

    assign smp_stb = (smp_cnt == '0);

    always_ff @(posedge i_sysclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            smp_cnt <= '0;
            scl_sr  <= 3'b111;
            sda_sr  <= 3'b111;
            o_line  <= '{scl: 1'b1, sda: 1'b1};
        end else if (smp_stb) begin
            smp_cnt    <= i_cfg.dfsr;
            scl_sr     <= {scl_sr[1:0], i_line.scl};
            sda_sr     <= {sda_sr[1:0], i_line.sda};
            o_line.scl <= maj3(scl_sr);   // one glitch sample is outvoted
            o_line.sda <= maj3(sda_sr);
        end else begin
            smp_cnt <= smp_cnt - 1'b1;
        end
    end

    // start and stop seen on the filtered lines
    assign sta_det = line_q.sda & ~o_line.sda & line_q.scl & o_line.scl;
    assign sto_det = ~line_q.sda & o_line.sda & line_q.scl & o_line.scl;

    always_ff @(posedge i_sysclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            line_q <= '{scl: 1'b1, sda: 1'b1};
            o_busy <= 1'b0;
        end else begin
            line_q <= o_line;
            if (sta_det) begin
                o_busy <= 1'b1;
            end else if (sto_det) begin
                o_busy <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/i2c_pkg.sv ====
`include "i2c_defines.svh"

package i2c_pkg;

    // byte-level commands from the host
    typedef enum logic [3:0] {
        CMD_IDLE    = 4'd0,
        CMD_START   = 4'd1,
        CMD_WRITE   = 4'd2,
        CMD_READ    = 4'd3,
        CMD_RD_ACK  = 4'd4,   // take slave ack after a write
        CMD_WR_ACK  = 4'd5,   // master ack after a read
        CMD_WR_NAK  = 4'd6,
        CMD_RESTART = 4'd7,
        CMD_STOP    = 4'd8
    } i2c_cmd_e;

    // bit-level commands to the bit controller
    typedef enum logic [2:0] {
        BIT_IDLE    = 3'd0,
        BIT_START   = 3'd1,
        BIT_WRITE   = 3'd2,
        BIT_READ    = 3'd3,
        BIT_RESTART = 3'd4,
        BIT_STOP    = 3'd5
    } i2c_bit_cmd_e;

    typedef struct packed {
        logic                       enable;
        logic [`I2C_PRESCALE_W-1:0] prescale;
        logic [`I2C_DFSR_W-1:0]     dfsr;
    } i2c_cfg_t;

    typedef struct packed {
        logic scl;
        logic sda;
    } i2c_line_t;

    typedef struct packed {
        logic scl_o;
        logic scl_oen;   // 1 releases the line
        logic sda_o;
        logic sda_oen;
    } i2c_pad_t;

    typedef struct packed {
        logic cmd_ack;
        logic ack;
        logic al;
        logic busy;
    } i2c_status_t;

endpackage

// ==== rtl/i2c_defines.svh ====
`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

// byte width on the bus
`define I2C_DATA_W      8

// scl phase length counter
`define I2C_PRESCALE_W  16

// input filter sampling rate counter
`define I2C_DFSR_W      6

`endif
